// ==== bench/rob_stim.txt ====
// Columns: op arg room retire, hex; op 0 nop, 1 enq, 2 done, 3 hwi, 4 flush
// room and retire are seen in the op cycle, f leaves them to the model; nop arg counts cycles
# enqueue until refused
1 01 c 0
1 04 c 0
1 03 b 0
1 04 8 0
1 02 4 0
1 03 2 0
0 01 2 0
# ring full up to head
1 02 2 0
1 01 0 0
0 01 0 0
# random done order
2 90 f f
0 12 c 0
# hwi reservation ahead of tail
3 06 c 0
1 04 6 0
1 03 2 0
1 02 2 0
0 01 0 0
# flush clears entries and reservations
4 00 0 0
0 01 c 0
1 04 c 0
0 01 c 0

// ==== tb.f ====
hdl/rob_pkg.sv
hdl/rob_queue_room.sv
hdl/rob_entry_store.sv
hdl/rob_pointers.sv
hdl/rob_ctrl_fsm.sv
hdl/rob_top.sv
bench/rob_chk.sv
bench/rob_tb.sv

// ==== Makefile ====
# Verilator build and run of the ROB entry tracker testbench

VERILATOR ?= verilator
TOP       ?= rob_tb
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "^RESULT: PASS$$" $(LOG) || (echo "simulation did not pass"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== bench/rob_tb.sv ====
// Testbench for the ROB entry tracker; replays bench/rob_stim.txt and checks a reference model
`timescale 1ns/1ns
`default_nettype none

module rob_tb;

	// ==============================
	// DUT signals
	// ==============================

	logic              clk;
	logic              arst_n;
	logic              enq;
	logic [2:0]        enq_count;
	logic              done;
	rob_pkg::rob_ndx_t done_index;
	logic              hwi_set;
	rob_pkg::rob_ndx_t hwi_index;
	logic              flush;
	logic [3:0]        room;
	logic              enq_ack;
	logic              retire;
	rob_pkg::rob_ndx_t retire_index;
	logic              busy;
	rob_pkg::rob_ndx_t head;
	rob_pkg::rob_ndx_t tail;

	// Reference copy of the ring flags and pointers
	logic [15:0] m_valid;
	logic [15:0] m_done;
	logic [15:0] m_hwi;
	int          m_head;
	int          m_tail;

	// Bookkeeping for the random picks and the report
	logic [31:0] lfsr;
	int          n_checks;
	int          n_errors;
	int          n_tests;
	int          test_errs;
	bit          timed_out;
	string       test_name;

	rob_top rob_top_i (
		.clk          (clk),
		.arst_n       (arst_n),
		.enq          (enq),
		.enq_count    (enq_count),
		.done         (done),
		.done_index   (done_index),
		.hwi_set      (hwi_set),
		.hwi_index    (hwi_index),
		.flush        (flush),
		.room         (room),
		.enq_ack      (enq_ack),
		.retire       (retire),
		.retire_index (retire_index),
		.busy         (busy),
		.head         (head),
		.tail         (tail)
	);

	initial clk = 1'b0;
	always #5 clk = ~clk;

	// ==============================
	// Helpers
	// ==============================

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		n_checks++;
		if (got !== exp) begin
			n_errors++;
			$display("FAIL %s: got 0x%0h expected 0x%0h", name, got, exp);
		end
	endtask

	// Galois form with taps at 32, 22, 2 and 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	// One LFSR step per bit taken
	task automatic take_bits(input int n, output int v);
		v = 0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v    = (v << 1) | int'(lfsr[0]);
		end
	endtask

	// Free run from the tail that stops at a used or reserved slot, at the head or at the cap
	function automatic int model_room();
		int cnt;
		int slot;
		cnt  = 0;
		slot = m_tail;
		while (cnt < rob_pkg::ROOM_MAX && !m_valid[slot] && !m_hwi[slot]
				&& !(cnt > 0 && slot == m_head)) begin
			cnt++;
			slot = (slot + 1) % rob_pkg::ROB_ENTRIES;
		end
		return cnt;
	endfunction

	// Random pick among entries that are valid and still waiting for execution
	task automatic pick_pending(output int idx);
		int pend[$];
		int r;
		for (int s = 0; s < rob_pkg::ROB_ENTRIES; s++) begin
			if (m_valid[s] && !m_done[s]) begin
				pend.push_back(s);
			end
		end
		idx = -1;
		if (pend.size() > 0) begin
			take_bits(4, r);
			idx = pend[r % pend.size()];
		end
	endtask

	task automatic drive_idle();
		enq        <= 1'b0;
		enq_count  <= 3'd0;
		done       <= 1'b0;
		done_index <= '0;
		hwi_set    <= 1'b0;
		hwi_index  <= '0;
		flush      <= 1'b0;
	endtask

	// Sample at the falling edge so only settled outputs are compared
	// The count returned is the number of samples that still saw busy high
	task automatic wait_not_busy(output int cycles);
		int cnt;
		cnt = 0;
		while (busy && cnt < 100) begin
			@(negedge clk);
			cnt++;
		end
		cycles = cnt;
		if (busy) begin
			timed_out = 1'b1;
			n_errors++;
			$display("busy did not fall within 100 cycles");
		end
	endtask

	// ==============================
	// One cycle of stimulus
	// ==============================

	task automatic step(input rob_pkg::rob_op_t op, input int arg, input int exp_room,
			input int exp_ret, input bit use_file);
		int p_room;
		bit p_ret;
		bit p_ack;
		int s;
		@(posedge clk);
		drive_idle();
		case (op)
			rob_pkg::OP_ENQ: begin
				enq       <= 1'b1;
				enq_count <= 3'(arg);
			end
			rob_pkg::OP_DONE: begin
				done       <= 1'b1;
				done_index <= rob_pkg::rob_ndx_t'(arg);
			end
			rob_pkg::OP_HWI: begin
				hwi_set   <= 1'b1;
				hwi_index <= rob_pkg::rob_ndx_t'(arg);
			end
			// An execute mark for the head lands with the flush, so the head
			// entry starts the sweep both valid and done
			rob_pkg::OP_FLUSH: begin
				flush      <= 1'b1;
				done       <= 1'b1;
				done_index <= rob_pkg::rob_ndx_t'(m_head);
			end
			default: begin
			end
		endcase
		// Predictions come from the state this cycle runs in
		p_room = model_room();
		p_ret  = m_valid[m_head] && m_done[m_head];
		p_ack  = (op == rob_pkg::OP_ENQ) && (arg <= p_room);
		@(negedge clk);
		check_value("room", 32'(room), 32'(p_room));
		check_value("enq_ack", 32'(enq_ack), 32'(p_ack));
		check_value("retire", 32'(retire), 32'(p_ret));
		check_value("head", 32'(head), 32'(m_head));
		check_value("tail", 32'(tail), 32'(m_tail));
		check_value("busy", 32'(busy), 32'd0);
		if (p_ret) begin
			check_value("retire_index", 32'(retire_index), 32'(m_head));
		end
		if (use_file && exp_room != 'hf) begin
			check_value("room", 32'(room), 32'(exp_room));
		end
		if (use_file && exp_ret != 'hf) begin
			check_value("retire", 32'(retire), 32'(exp_ret));
		end
		// Apply what the coming edge does to the ring
		if (p_ret) begin
			m_valid[m_head] = 1'b0;
			m_done[m_head]  = 1'b0;
			m_hwi[m_head]   = 1'b0;
			m_head          = (m_head + 1) % rob_pkg::ROB_ENTRIES;
		end
		if (p_ack) begin
			for (int j = 0; j < arg; j++) begin
				s          = (m_tail + j) % rob_pkg::ROB_ENTRIES;
				m_valid[s] = 1'b1;
				m_done[s]  = 1'b0;
				m_hwi[s]   = 1'b0;
			end
			m_tail = (m_tail + arg) % rob_pkg::ROB_ENTRIES;
		end
		if (op == rob_pkg::OP_DONE) begin
			m_done[arg] = 1'b1;
		end
		if (op == rob_pkg::OP_HWI) begin
			m_hwi[arg] = 1'b1;
		end
	endtask

	// Drive every input during the first half of the sweep and expect no reaction
	// The head is valid and done here, so only the sweep holds retire off
	// Busy must then stay high for exactly one sweep of the ring
	task automatic sweep_ignored();
		int busy_cnt;
		int cycles;
		busy_cnt = 0;
		for (int c = 0; c < 8; c++) begin
			@(posedge clk);
			drive_idle();
			enq       <= 1'b1;
			enq_count <= 3'd1;
			done      <= 1'b1;
			hwi_set   <= 1'b1;
			hwi_index <= 4'd5;
			flush     <= 1'b1;
			@(negedge clk);
			check_value("busy", 32'(busy), 32'd1);
			check_value("enq_ack", 32'(enq_ack), 32'd0);
			check_value("retire", 32'(retire), 32'd0);
			busy_cnt++;
		end
		@(posedge clk);
		drive_idle();
		@(negedge clk);
		wait_not_busy(cycles);
		if (!timed_out) begin
			busy_cnt = busy_cnt + cycles;
			check_value("busy cycles", 32'(busy_cnt), 32'(rob_pkg::ROB_ENTRIES));
			check_value("room", 32'(room), 32'(rob_pkg::ROOM_MAX));
			check_value("head", 32'(head), 32'd0);
			check_value("tail", 32'(tail), 32'd0);
		end
		m_valid = '0;
		m_done  = '0;
		m_hwi   = '0;
		m_head  = 0;
		m_tail  = 0;
	endtask

	// A nop arg counts idle cycles; a done arg of 80 hex or more marks arg minus 80 hex
	// random entries
	task automatic run_line(input int op_v, input int arg_v, input int room_v, input int ret_v);
		rob_pkg::rob_op_t op;
		int               reps;
		int               idx;
		op = rob_pkg::rob_op_t'(op_v[2:0]);
		if (op == rob_pkg::OP_NOP) begin
			reps = (arg_v > 1) ? arg_v : 1;
			for (int r = 0; r < reps; r++) begin
				step(op, 0, room_v, ret_v, r == reps - 1);
			end
		end else if (op == rob_pkg::OP_DONE && arg_v >= 'h80) begin
			reps = arg_v - 'h80;
			for (int r = 0; r < reps; r++) begin
				pick_pending(idx);
				if (idx < 0) begin
					n_errors++;
					$display("random done found no pending entry");
					step(rob_pkg::OP_NOP, 0, room_v, ret_v, 1'b0);
				end else begin
					step(op, idx, room_v, ret_v, r == reps - 1);
				end
			end
		end else begin
			step(op, arg_v, room_v, ret_v, 1'b1);
			if (op == rob_pkg::OP_FLUSH) begin
				sweep_ignored();
			end
		end
	endtask

	task automatic finish_test();
		if (test_name != "") begin
			n_tests++;
			if (n_errors == test_errs) begin
				$display("test %0d %s: ok", n_tests, test_name);
			end else begin
				$display("test %0d %s: %0d errors", n_tests, test_name, n_errors - test_errs);
			end
		end
		test_name = "";
		test_errs = n_errors;
	endtask

	// ==============================
	// Main sequence
	// ==============================

	initial begin
		int    fd;
		int    rc;
		int    last;
		int    cycles;
		string line;
		int    op_v;
		int    arg_v;
		int    room_v;
		int    ret_v;
		arst_n     = 1'b0;
		enq        = 1'b0;
		enq_count  = 3'd0;
		done       = 1'b0;
		done_index = '0;
		hwi_set    = 1'b0;
		hwi_index  = '0;
		flush      = 1'b0;
		m_valid    = '0;
		m_done     = '0;
		m_hwi      = '0;
		m_head     = 0;
		m_tail     = 0;
		lfsr       = 32'h12f70d2a;
		n_checks   = 0;
		n_errors   = 0;
		n_tests    = 0;
		test_errs  = 0;
		timed_out  = 1'b0;
		test_name  = "reset sweep";
		repeat (16) @(posedge clk);
		arst_n <= 1'b1;
		@(negedge clk);
		wait_not_busy(cycles);
		if (!timed_out) begin
			check_value("busy cycles", 32'(cycles), 32'(rob_pkg::ROB_ENTRIES));
			check_value("room", 32'(room), 32'(rob_pkg::ROOM_MAX));
			check_value("head", 32'(head), 32'd0);
			check_value("tail", 32'(tail), 32'd0);
		end
		finish_test();
		fd = $fopen("bench/rob_stim.txt", "r");
		if (fd == 0) begin
			n_errors++;
			$display("could not open bench/rob_stim.txt");
		end else begin
			// Lines starting with # open a named test; comment lines do not parse
			while (!$feof(fd) && !timed_out) begin
				line = "";
				rc   = $fgets(line, fd);
				if (rc > 0 && line.getc(0) == "#") begin
					finish_test();
					last = line.len() - 1;
					if (line.getc(last) == 8'h0a) begin
						last--;
					end
					test_name = (last >= 2) ? line.substr(2, last) : "unnamed";
				end else if ($sscanf(line, "%h %h %h %h", op_v, arg_v, room_v, ret_v) == 4) begin
					run_line(op_v, arg_v, room_v, ret_v);
				end
			end
			$fclose(fd);
			finish_test();
		end
		$display("tests %0d, checks %0d, errors %0d", n_tests, n_checks, n_errors);
		if (n_errors == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== bench/rob_chk.sv ====
// Assertion checker bound into the ROB top level to watch room range and run-time sequencing
`timescale 1ns/1ns
`default_nettype none

module rob_chk (
	input wire logic              clk,
	input wire logic              arst_n,
	input wire logic [3:0]        room,
	input wire logic              enq_ack,
	input wire logic              retire,
	input wire logic              busy,
	input wire rob_pkg::rob_ndx_t tail
);

	// ==============================
	// Range and sequencing
	// ==============================

	// Dispatch is never offered more than the cap
	room_cap: assert property (@(posedge clk) disable iff (!arst_n)
		room <= 4'(rob_pkg::ROOM_MAX))
		else $error("room %0d is above the cap", room);

	// No group is taken while a sweep is clearing the ring
	ack_idle: assert property (@(posedge clk) disable iff (!arst_n) !(enq_ack && busy))
		else $error("enq_ack while busy");

	// The head must stay put during a sweep
	retire_idle: assert property (@(posedge clk) disable iff (!arst_n) !(retire && busy))
		else $error("retire while busy");

	// In run mode the tail only moves for an accepted group
	tail_hold: assert property (@(posedge clk) disable iff (!arst_n)
		(!enq_ack && !busy) |=> $stable(tail))
		else $error("tail moved without enq_ack");

endmodule

bind rob_top rob_chk rob_chk_i (
	.clk     (clk),
	.arst_n  (arst_n),
	.room    (room),
	.enq_ack (enq_ack),
	.retire  (retire),
	.busy    (busy),
	.tail    (tail)
);

`default_nettype wire

// ==== hdl/rob_top.sv ====
// Top level of the ROB entry tracker, connecting control, pointers, flag store and room counter
`timescale 1ns/1ns
`default_nettype none

module rob_top (
	input  wire logic              clk,
	input  wire logic              arst_n,
	input  wire logic              enq,
	input  wire logic [2:0]        enq_count,
	input  wire logic              done,
	input  wire rob_pkg::rob_ndx_t done_index,
	input  wire logic              hwi_set,
	input  wire rob_pkg::rob_ndx_t hwi_index,
	input  wire logic              flush,
	output logic [3:0]             room,
	output logic                   enq_ack,
	output logic                   retire,
	output rob_pkg::rob_ndx_t      retire_index,
	output logic                   busy,
	output rob_pkg::rob_ndx_t      head,
	output rob_pkg::rob_ndx_t      tail
);

	// ==============================
	// Internal nets
	// ==============================

	logic                            sweep_en;
	logic                            ptr_clear;
	logic                            run;
	logic                            sweep_last;
	rob_pkg::rob_ndx_t               sweep_index;
	logic [rob_pkg::ROB_ENTRIES-1:0] entry_valid;
	logic [rob_pkg::ROB_ENTRIES-1:0] entry_done;
	logic [rob_pkg::ROB_ENTRIES-1:0] entry_hwi;

	// The only place room is checked; an oversized group is dropped, not stalled
	assign enq_ack = enq && run && ({1'b0, enq_count} <= room);

	// ==============================
	// Instances
	// ==============================

	rob_ctrl_fsm rob_ctrl_fsm_i (
		.clk        (clk),
		.arst_n     (arst_n),
		.flush      (flush),
		.sweep_last (sweep_last),
		.sweep_en   (sweep_en),
		.ptr_clear  (ptr_clear),
		.run        (run),
		.busy       (busy)
	);

	rob_pointers rob_pointers_i (
		.clk         (clk),
		.arst_n      (arst_n),
		.run         (run),
		.enq_ack     (enq_ack),
		.enq_count   (enq_count),
		.retire      (retire),
		.sweep_en    (sweep_en),
		.ptr_clear   (ptr_clear),
		.head        (head),
		.tail        (tail),
		.sweep_index (sweep_index),
		.sweep_last  (sweep_last)
	);

	rob_entry_store rob_entry_store_i (
		.clk          (clk),
		.arst_n       (arst_n),
		.run          (run),
		.head         (head),
		.tail         (tail),
		.enq_ack      (enq_ack),
		.enq_count    (enq_count),
		.done         (done),
		.done_index   (done_index),
		.hwi_set      (hwi_set),
		.hwi_index    (hwi_index),
		.sweep_en     (sweep_en),
		.sweep_index  (sweep_index),
		.entry_valid  (entry_valid),
		.entry_done   (entry_done),
		.entry_hwi    (entry_hwi),
		.retire       (retire),
		.retire_index (retire_index)
	);

	// Executed flags play no part in room, only occupancy and reservations do
	rob_queue_room rob_queue_room_i (
		.entry_valid (entry_valid),
		.entry_hwi   (entry_hwi),
		.head        (head),
		.tail        (tail),
		.room        (room)
	);

endmodule

`default_nettype wire

// ==== hdl/rob_ctrl_fsm.sv ====
// State machine that runs the clearing sweep after reset and after a flush, then enables the ROB
`timescale 1ns/1ns
`default_nettype none

module rob_ctrl_fsm (
	input  wire logic clk,
	input  wire logic arst_n,
	input  wire logic flush,
	input  wire logic sweep_last,
	output logic      sweep_en,
	output logic      ptr_clear,
	output logic      run,
	output logic      busy
);

	rob_pkg::rob_state_t state;
	rob_pkg::rob_state_t state_nxt;

	// ==============================
	// State register
	// ==============================

	// Reset lands in the clearing sweep so no stale flag survives power-up
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= rob_pkg::ST_CLEAR;
		end else begin
			state <= state_nxt;
		end
	end

	// ==============================
	// Next state
	// ==============================

	// Both sweeps end on the last slot and go back to normal running
	// A flush is only taken while running; during a sweep it is ignored
	always_comb begin
		state_nxt = state;
		case (state)
			rob_pkg::ST_CLEAR: begin
				if (sweep_last) begin
					state_nxt = rob_pkg::ST_RUN;
				end
			end
			rob_pkg::ST_RUN: begin
				if (flush) begin
					state_nxt = rob_pkg::ST_FLUSH;
				end
			end
			rob_pkg::ST_FLUSH: begin
				if (sweep_last) begin
					state_nxt = rob_pkg::ST_RUN;
				end
			end
			default: state_nxt = rob_pkg::ST_CLEAR;
		endcase
	end

	// ==============================
	// Outputs
	// ==============================

	// Sweeping covers both clearing states
	assign sweep_en  = (state == rob_pkg::ST_CLEAR) || (state == rob_pkg::ST_FLUSH);

	// Pointers reset together with the clearing of the final slot
	assign ptr_clear = sweep_en && sweep_last;

	assign run       = (state == rob_pkg::ST_RUN);

	// Dispatch and execute must hold off for the whole sweep
	assign busy      = (state != rob_pkg::ST_RUN);

endmodule

`default_nettype wire

// ==== hdl/rob_pointers.sv ====
// Head, tail and sweep index counters of the ROB ring, all wrapping modulo 16
`timescale 1ns/1ns
`default_nettype none

module rob_pointers (
	input  wire logic              clk,
	input  wire logic              arst_n,
	input  wire logic              run,
	input  wire logic              enq_ack,
	input  wire logic [2:0]        enq_count,
	input  wire logic              retire,
	input  wire logic              sweep_en,
	input  wire logic              ptr_clear,
	output rob_pkg::rob_ndx_t      head,
	output rob_pkg::rob_ndx_t      tail,
	output rob_pkg::rob_ndx_t      sweep_index,
	output logic                   sweep_last
);

	// ==============================
	// Ring pointers
	// ==============================

	// Pointers return to slot 0 when a sweep finishes
	// Tail moves by the whole dispatch group, head by one retired entry
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			head <= '0;
			tail <= '0;
		end else if (ptr_clear) begin
			head <= '0;
			tail <= '0;
		end else if (run) begin
			if (enq_ack) begin
				tail <= tail + {1'b0, enq_count};
			end
			if (retire) begin
				head <= head + 4'd1;
			end
		end
	end

	// ==============================
	// Sweep counter
	// ==============================

	// Walks every slot once; the 4-bit wrap brings it back to 0 after 15
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			sweep_index <= '0;
		end else if (sweep_en) begin
			sweep_index <= sweep_index + 4'd1;
		end
	end

	// Marks the final slot of a sweep
	assign sweep_last = (sweep_index == rob_pkg::rob_ndx_t'(rob_pkg::ROB_ENTRIES - 1));

endmodule

`default_nettype wire

// ==== hdl/rob_entry_store.sv ====
// Per-entry valid, done and hwi flags of the ROB, updated by dispatch, execute, retire and sweep
`timescale 1ns/1ns
`default_nettype none

module rob_entry_store (
	input  wire logic                            clk,
	input  wire logic                            arst_n,
	input  wire logic                            run,
	input  wire rob_pkg::rob_ndx_t               head,
	input  wire rob_pkg::rob_ndx_t               tail,
	input  wire logic                            enq_ack,
	input  wire logic [2:0]                      enq_count,
	input  wire logic                            done,
	input  wire rob_pkg::rob_ndx_t               done_index,
	input  wire logic                            hwi_set,
	input  wire rob_pkg::rob_ndx_t               hwi_index,
	input  wire logic                            sweep_en,
	input  wire rob_pkg::rob_ndx_t               sweep_index,
	output logic [rob_pkg::ROB_ENTRIES-1:0]      entry_valid,
	output logic [rob_pkg::ROB_ENTRIES-1:0]      entry_done,
	output logic [rob_pkg::ROB_ENTRIES-1:0]      entry_hwi,
	output logic                                 retire,
	output rob_pkg::rob_ndx_t                    retire_index
);

	// Distance of each slot from the tail, used to find the enqueue window
	rob_pkg::rob_ndx_t enq_off [rob_pkg::ROB_ENTRIES];

	// Write command chosen for each slot this cycle
	rob_pkg::rob_op_t entry_cmd [rob_pkg::ROB_ENTRIES];

	// ==============================
	// Retire
	// ==============================

	// The oldest entry leaves once it has been executed
	assign retire       = run && entry_valid[head] && entry_done[head];
	assign retire_index = head;

	// ==============================
	// Per-slot command decode
	// ==============================

	// Clearing wins over everything, then a new dispatch, then execute marks
	// Room never covers a valid head, so dispatch and retire cannot share a slot
	always_comb begin
		for (int i = 0; i < rob_pkg::ROB_ENTRIES; i++) begin
			enq_off[i]   = rob_pkg::rob_ndx_t'(i) - tail;
			entry_cmd[i] = rob_pkg::OP_NOP;
			if (sweep_en && sweep_index == rob_pkg::rob_ndx_t'(i)) begin
				entry_cmd[i] = rob_pkg::OP_FLUSH;
			end else if (retire && head == rob_pkg::rob_ndx_t'(i)) begin
				entry_cmd[i] = rob_pkg::OP_FLUSH;
			end else if (run && enq_ack && enq_off[i] < {1'b0, enq_count}) begin
				entry_cmd[i] = rob_pkg::OP_ENQ;
			end else if (run && done && done_index == rob_pkg::rob_ndx_t'(i)) begin
				entry_cmd[i] = rob_pkg::OP_DONE;
			end else if (run && hwi_set && hwi_index == rob_pkg::rob_ndx_t'(i)) begin
				entry_cmd[i] = rob_pkg::OP_HWI;
			end
		end
	end

	// ==============================
	// Flag registers
	// ==============================

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			entry_valid <= '0;
			entry_done  <= '0;
			entry_hwi   <= '0;
		end else begin
			for (int i = 0; i < rob_pkg::ROB_ENTRIES; i++) begin
				case (entry_cmd[i])
					rob_pkg::OP_FLUSH: begin
						entry_valid[i] <= 1'b0;
						entry_done[i]  <= 1'b0;
						entry_hwi[i]   <= 1'b0;
					end
					// A fresh entry starts unexecuted and takes over any reservation
					rob_pkg::OP_ENQ: begin
						entry_valid[i] <= 1'b1;
						entry_done[i]  <= 1'b0;
						entry_hwi[i]   <= 1'b0;
					end
					rob_pkg::OP_DONE: entry_done[i] <= 1'b1;
					rob_pkg::OP_HWI:  entry_hwi[i]  <= 1'b1;
					default: begin
					end
				endcase
			end
		end
	end

endmodule

`default_nettype wire

// ==== hdl/rob_queue_room.sv ====
// Combinational free-slot counter that tells dispatch how many entries fit ahead of the tail
`timescale 1ns/1ns
`default_nettype none

module rob_queue_room (
	input  wire logic [rob_pkg::ROB_ENTRIES-1:0] entry_valid,
	input  wire logic [rob_pkg::ROB_ENTRIES-1:0] entry_hwi,
	input  wire rob_pkg::rob_ndx_t               head,
	input  wire rob_pkg::rob_ndx_t               tail,
	output logic [3:0]                           room
);

	// ==============================
	// Slot walk
	// ==============================

	// Ring slot examined at the current offset of the walk
	rob_pkg::rob_ndx_t slot;

	// Stays high while every slot walked so far is usable
	logic run_open;

	// Length of the free run found so far
	logic [3:0] run_len;

	// The walk covers at most ROOM_MAX slots, which also caps the answer
	// A slot is usable when it holds no instruction and no interrupt reservation
	// Reaching the head slot ends the run, except at offset 0
	// At offset 0 the head slot can only be free when the ring is empty, and the
	// free test below already rejects it in every other case
	always_comb begin
		slot     = tail;
		run_open = 1'b1;
		run_len  = 4'd0;
		for (int k = 0; k < rob_pkg::ROOM_MAX; k++) begin
			slot = tail + rob_pkg::rob_ndx_t'(k);
			// Dispatch may never wrap onto the oldest entry
			if (k != 0 && slot == head) begin
				run_open = 1'b0;
			end
			// A reserved or occupied slot blocks everything beyond it
			if (entry_valid[slot] || entry_hwi[slot]) begin
				run_open = 1'b0;
			end
			if (run_open) begin
				run_len = run_len + 4'd1;
			end
		end
	end

	// The run length is the room reported to dispatch
	assign room = run_len;

endmodule

`default_nettype wire

// ==== hdl/rob_pkg.sv ====
// Shared sizes, ring index type and enums for the ROB entry tracker, referenced by scoped name
`default_nettype none

package rob_pkg;

	// ==============================
	// Sizes
	// ==============================

	// Number of slots in the reorder ring
	localparam int ROB_ENTRIES = 16;

	// Largest room value ever reported to dispatch
	localparam int ROOM_MAX = 12;

	// Dispatch width, the most entries written in one cycle
	localparam int ENQ_MAX = 4;

	// ==============================
	// Types
	// ==============================

	// Ring index, wraps naturally modulo 16
	typedef logic [3:0] rob_ndx_t;

	// Control states; both sweep states clear one entry per cycle
	typedef enum logic [1:0] {
		ST_CLEAR,
		ST_RUN,
		ST_FLUSH
	} rob_state_t;

	// Command codes shared by the stimulus decoder and the entry store
	// The store reuses OP_FLUSH as its per-entry clear command
	typedef enum logic [2:0] {
		OP_NOP,
		OP_ENQ,
		OP_DONE,
		OP_HWI,
		OP_FLUSH
	} rob_op_t;

endpackage

`default_nettype wire
